//--- design/instruction_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_scheduler (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 flush_in,
    input  sched_pkg::apb_req_t  apb_req,
    output sched_pkg::apb_rsp_t  apb_rsp,
    // load/store unit
    input  logic                 lsu_valid,
    input  sched_pkg::mem_uop_t  lsu_uop,
    output logic                 lsu_ready,
    output logic                 lsu_issue_valid,
    output sched_pkg::mem_uop_t  lsu_issue_uop,
    input  logic                 lsu_fu_ready,
    output logic                 lsu_executing,
    output sched_pkg::rob_tag_t  lsu_executing_tag,
    // branch unit
    input  logic                 bru_valid,
    input  sched_pkg::exec_uop_t bru_uop,
    output logic                 bru_ready,
    output logic                 bru_issue_valid,
    output sched_pkg::exec_uop_t bru_issue_uop,
    input  logic                 bru_fu_ready,
    output logic                 bru_executing,
    output sched_pkg::rob_tag_t  bru_executing_tag,
    // integer unit
    input  logic                 alu_valid,
    input  sched_pkg::exec_uop_t alu_uop,
    output logic                 alu_ready,
    output logic                 alu_issue_valid,
    output sched_pkg::exec_uop_t alu_issue_uop,
    input  logic                 alu_fu_ready,
    output logic                 alu_executing,
    output sched_pkg::rob_tag_t  alu_executing_tag,
    // floating point unit
    input  logic                 fpu_valid,
    input  sched_pkg::exec_uop_t fpu_uop,
    output logic                 fpu_ready,
    output logic                 fpu_issue_valid,
    output sched_pkg::exec_uop_t fpu_issue_uop,
    input  logic                 fpu_fu_ready,
    output logic                 fpu_executing,
    output sched_pkg::rob_tag_t  fpu_executing_tag
);
    import sched_pkg::*;

    logic [OCC_W-1:0]  occupancy [NUM_FU];
    logic              issued [NUM_FU];
    logic [NUM_FU-1:0] fu_enable;
    logic [OCC_W-1:0]  thresh [NUM_FU];

    issue_queue #(.entry_t(mem_uop_t)) u_lsu_iq (
        .clk_in, .arst_n, .flush_in,
        .enq_valid(lsu_valid), .enq_uop(lsu_uop), .enq_ready(lsu_ready),
        .issue_valid(lsu_issue_valid), .issue_uop(lsu_issue_uop),
        .fu_ready(lsu_fu_ready),
        .executing(lsu_executing), .executing_tag(lsu_executing_tag),
        .enable(fu_enable[FU_LSU]), .thresh(thresh[FU_LSU]),
        .occupancy(occupancy[FU_LSU]), .issued(issued[FU_LSU])
    );

    issue_queue #(.entry_t(exec_uop_t)) u_bru_iq (
        .clk_in, .arst_n, .flush_in,
        .enq_valid(bru_valid), .enq_uop(bru_uop), .enq_ready(bru_ready),
        .issue_valid(bru_issue_valid), .issue_uop(bru_issue_uop),
        .fu_ready(bru_fu_ready),
        .executing(bru_executing), .executing_tag(bru_executing_tag),
        .enable(fu_enable[FU_BRU]), .thresh(thresh[FU_BRU]),
        .occupancy(occupancy[FU_BRU]), .issued(issued[FU_BRU])
    );

    issue_queue #(.entry_t(exec_uop_t)) u_alu_iq (
        .clk_in, .arst_n, .flush_in,
        .enq_valid(alu_valid), .enq_uop(alu_uop), .enq_ready(alu_ready),
        .issue_valid(alu_issue_valid), .issue_uop(alu_issue_uop),
        .fu_ready(alu_fu_ready),
        .executing(alu_executing), .executing_tag(alu_executing_tag),
        .enable(fu_enable[FU_ALU]), .thresh(thresh[FU_ALU]),
        .occupancy(occupancy[FU_ALU]), .issued(issued[FU_ALU])
    );

    issue_queue #(.entry_t(exec_uop_t)) u_fpu_iq (
        .clk_in, .arst_n, .flush_in,
        .enq_valid(fpu_valid), .enq_uop(fpu_uop), .enq_ready(fpu_ready),
        .issue_valid(fpu_issue_valid), .issue_uop(fpu_issue_uop),
        .fu_ready(fpu_fu_ready),
        .executing(fpu_executing), .executing_tag(fpu_executing_tag),
        .enable(fu_enable[FU_FPU]), .thresh(thresh[FU_FPU]),
        .occupancy(occupancy[FU_FPU]), .issued(issued[FU_FPU])
    );

    // enables and thresholds steer the queues, occupancy and issue pulses come back
    sched_csr u_csr (
        .clk_in,
        .arst_n,
        .apb_req,
        .apb_rsp,
        .occupancy,
        .issued,
        .fu_enable,
        .thresh
    );

endmodule

`default_nettype wire

//--- design/issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

module issue_queue #(
    parameter type entry_t = sched_pkg::exec_uop_t
) (
    input  logic                        clk_in,
    input  logic                        arst_n,
    input  logic                        flush_in,
    // reorder buffer side
    input  logic                        enq_valid,
    input  entry_t                      enq_uop,
    output logic                        enq_ready,
    // functional unit side
    output logic                        issue_valid,
    output entry_t                      issue_uop,
    input  logic                        fu_ready,
    output logic                        executing,
    output sched_pkg::rob_tag_t         executing_tag,
    // register block side
    input  logic                        enable,
    input  logic [sched_pkg::OCC_W-1:0] thresh,
    output logic [sched_pkg::OCC_W-1:0] occupancy,
    output logic                        issued
);
    import sched_pkg::*;

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int ENTRY_W = $bits(entry_t);

    entry_t             mem [IQ_DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [OCC_W-1:0]   count;
    logic               active;
    logic               enq_fire;
    rob_tag_t           head_tag;

    // wrap pointer, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(IQ_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ready drops early once the programmed threshold is reached
    assign enq_ready = active && (count < thresh) && (count < OCC_W'(IQ_DEPTH));
    assign enq_fire = enq_valid && enq_ready && !flush_in;

    // strictly in order, only the head may leave
    assign issue_valid = enable && (count != '0);
    assign issue_uop = mem[head];
    assign issued = issue_valid && fu_ready;

    assign head_tag = issue_uop[ENTRY_W-1 -: ROB_TAG_W];
    assign occupancy = count;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            executing <= 1'b0;
            active <= 1'b0;
        end else begin
            // holds ready low until the first edge after reset release
            active <= 1'b1;
            if (flush_in) begin
                head <= '0;
                tail <= '0;
                count <= '0;
                executing <= 1'b0;
            end else begin
                if (enq_fire) begin
                    tail <= next_ptr(tail);
                end
                if (issued) begin
                    head <= next_ptr(head);
                end
                case ({enq_fire, issued})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
                executing <= issued;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (enq_fire) begin
            mem[tail] <= enq_uop;
        end
    end

    // tag reported to the reorder buffer one cycle after issue
    always_ff @(posedge clk_in) begin
        if (issued) begin
            executing_tag <= head_tag;
        end
    end

endmodule

`default_nettype wire

//--- design/sched_csr.sv
`timescale 1ns/1ns
`default_nettype none

module sched_csr (
    input  logic                         clk_in,
    input  logic                         arst_n,
    input  sched_pkg::apb_req_t          apb_req,
    output sched_pkg::apb_rsp_t          apb_rsp,
    input  logic [sched_pkg::OCC_W-1:0]  occupancy [sched_pkg::NUM_FU],
    input  logic                         issued [sched_pkg::NUM_FU],
    output logic [sched_pkg::NUM_FU-1:0] fu_enable,
    output logic [sched_pkg::OCC_W-1:0]  thresh [sched_pkg::NUM_FU]
);
    import sched_pkg::*;

    logic [CNT_W-1:0]  cnt_q [NUM_FU];
    logic              sel_ctrl;
    logic              sel_thresh;
    logic              sel_status;
    logic [NUM_FU-1:0] sel_cnt;
    logic              addr_ok;
    logic              access;
    logic              wr_ok;
    logic              slverr;
    logic [31:0]       rdata;

    // address decode
    always_comb begin
        sel_ctrl = 1'b0;
        sel_thresh = 1'b0;
        sel_status = 1'b0;
        sel_cnt = '0;
        case (apb_req.paddr)
            REG_CTRL:   sel_ctrl = 1'b1;
            REG_THRESH: sel_thresh = 1'b1;
            REG_STATUS: sel_status = 1'b1;
            REG_CNT0:   sel_cnt[0] = 1'b1;
            REG_CNT1:   sel_cnt[1] = 1'b1;
            REG_CNT2:   sel_cnt[2] = 1'b1;
            REG_CNT3:   sel_cnt[3] = 1'b1;
            default:    ;
        endcase
    end

    assign addr_ok = sel_ctrl || sel_thresh || sel_status || (|sel_cnt);
    assign access = apb_req.psel && apb_req.penable;

    // status is read only, a write there is rejected
    assign wr_ok = access && apb_req.pwrite && addr_ok && !sel_status;
    assign slverr = access && (!addr_ok || (apb_req.pwrite && sel_status));

    // read mux, one field of four bits per unit
    always_comb begin
        rdata = '0;
        if (sel_ctrl) begin
            rdata[NUM_FU-1:0] = fu_enable;
        end
        for (int i = 0; i < NUM_FU; i++) begin
            if (sel_thresh) begin
                rdata[i*OCC_W +: OCC_W] = thresh[i];
            end
            if (sel_status) begin
                rdata[i*OCC_W +: OCC_W] = occupancy[i];
            end
            if (sel_cnt[i]) begin
                rdata[CNT_W-1:0] = cnt_q[i];
            end
        end
    end

    assign apb_rsp = '{prdata: rdata, pslverr: slverr};

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            fu_enable <= CTRL_RESET;
            for (int i = 0; i < NUM_FU; i++) begin
                thresh[i] <= THRESH_RESET;
            end
        end else if (wr_ok) begin
            if (sel_ctrl) begin
                fu_enable <= apb_req.pwdata[NUM_FU-1:0];
            end
            if (sel_thresh) begin
                for (int i = 0; i < NUM_FU; i++) begin
                    thresh[i] <= apb_req.pwdata[i*OCC_W +: OCC_W];
                end
            end
        end
    end

    // issue counters saturate, a write of any value clears
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_FU; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (wr_ok && sel_cnt[i]) begin
                    cnt_q[i] <= '0;
                end else if (issued[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sched_pkg.sv
`default_nettype none

package sched_pkg;

    // queue geometry
    localparam int IQ_DEPTH = 8;
    localparam int OCC_W = 4;

    // functional unit indices
    localparam int NUM_FU = 4;
    localparam int FU_LSU = 0;
    localparam int FU_BRU = 1;
    localparam int FU_ALU = 2;
    localparam int FU_FPU = 3;

    localparam int ROB_TAG_W = 5;
    localparam int CNT_W = 16;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // tag must stay the first field, the queue slices it from the top bits
    typedef struct packed {
        rob_tag_t    tag;
        logic [5:0]  opcode;
        logic [31:0] src_a;
        logic [31:0] src_b;
    } exec_uop_t;

    typedef struct packed {
        rob_tag_t    tag;
        logic [5:0]  opcode;
        logic [31:0] base;
        logic [11:0] offset;
        logic        is_store;
    } mem_uop_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [7:0] REG_CTRL = 8'h00;
    localparam logic [7:0] REG_THRESH = 8'h04;
    localparam logic [7:0] REG_STATUS = 8'h08;
    localparam logic [7:0] REG_CNT0 = 8'h0C;
    localparam logic [7:0] REG_CNT1 = 8'h10;
    localparam logic [7:0] REG_CNT2 = 8'h14;
    localparam logic [7:0] REG_CNT3 = 8'h18;

    localparam logic [NUM_FU-1:0] CTRL_RESET = 4'hF;
    localparam logic [OCC_W-1:0] THRESH_RESET = 4'd8;

endpackage

`default_nettype wire

//--- sources.f
design/sched_pkg.sv
design/issue_queue.sv
design/sched_csr.sv
design/instruction_scheduler.sv
verification/instruction_scheduler_chk.sv
verification/instruction_scheduler_tb.sv

//--- verification/instruction_scheduler_chk.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_scheduler_chk (
    input logic                        clk_in,
    input logic                        arst_n,
    input logic                        flush_in,
    input logic                        enable,
    input logic [sched_pkg::OCC_W-1:0] thresh,
    input logic [sched_pkg::OCC_W-1:0] occupancy,
    input logic                        enq_ready,
    input logic                        issue_valid,
    input logic                        fu_ready,
    input logic                        executing
);
    import sched_pkg::*;

    // failures seen so far, read by the testbench
    int unsigned fail_count = 0;

    occ_bound_a: assert property (@(posedge clk_in) disable iff (!arst_n)
        occupancy <= OCC_W'(IQ_DEPTH))
        else begin
            $error("occupancy above queue depth");
            fail_count = fail_count + 1;
        end

    // a disabled unit never lets an entry leave
    issue_enable_a: assert property (@(posedge clk_in) disable iff (!arst_n)
        (!enable && !flush_in) |=> (occupancy >= $past(occupancy)))
        else begin
            $error("an entry left the queue while the unit is disabled");
            fail_count = fail_count + 1;
        end

    exec_after_issue_a: assert property (@(posedge clk_in) disable iff (!arst_n)
        (issue_valid && fu_ready && !flush_in) |=> executing)
        else begin
            $error("executing missing one cycle after issue");
            fail_count = fail_count + 1;
        end

    exec_cause_a: assert property (@(posedge clk_in) disable iff (!arst_n)
        executing |-> $past(issue_valid && fu_ready && !flush_in))
        else begin
            $error("executing without an issue transfer");
            fail_count = fail_count + 1;
        end

    // at or above the threshold no enqueue is accepted, so occupancy cannot grow
    thresh_ready_a: assert property (@(posedge clk_in) disable iff (!arst_n)
        (occupancy >= thresh) |=> (occupancy <= $past(occupancy)))
        else begin
            $error("entry accepted at or above threshold");
            fail_count = fail_count + 1;
        end

endmodule

bind issue_queue instruction_scheduler_chk chk0 (.*);

`default_nettype wire

//--- verification/instruction_scheduler_tb.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_scheduler_tb;
    import sched_pkg::*;

    localparam int ENTRY_W = $bits(exec_uop_t);
    localparam int MODEL_SIZE = 1024;

    logic clk_in = 1'b0;
    logic arst_n;
    logic flush_in;
    apb_req_t apb_req;
    wire apb_rsp_t apb_rsp;

    // per unit handshakes, index by FU_* constant
    logic [NUM_FU-1:0] valid;
    logic [NUM_FU-1:0] fu_ready;
    mem_uop_t lsu_in;
    exec_uop_t [NUM_FU-1:0] exec_in;
    wire [NUM_FU-1:0] ready;
    wire [NUM_FU-1:0] issue_valid;
    wire [NUM_FU-1:0] executing;
    wire rob_tag_t [NUM_FU-1:0] exec_tag;
    wire mem_uop_t lsu_out;
    wire exec_uop_t [NUM_FU-1:0] exec_out;

    // reference model state, owned by the monitor
    logic [ENTRY_W-1:0] model_mem [NUM_FU][MODEL_SIZE];
    int                 wr_ptr [NUM_FU];
    int                 rd_ptr [NUM_FU];
    logic [NUM_FU-1:0]  m_en;
    logic [OCC_W-1:0]   m_thr [NUM_FU];
    logic [CNT_W-1:0]   m_cnt [NUM_FU];
    logic               m_active;
    logic [NUM_FU-1:0]  exec_pend;
    rob_tag_t           pend_tag [NUM_FU];
    logic [NUM_FU-1:0]  accepted;

    rob_tag_t    next_tag [NUM_FU];
    logic [31:0] rng_state;
    logic [CNT_W-1:0] bru_before;
    int          cyc;
    string       names [NUM_FU] = '{"lsu", "bru", "alu", "fpu"};

    instruction_scheduler dut0 (
        .clk_in, .arst_n, .flush_in, .apb_req, .apb_rsp,
        .lsu_valid(valid[FU_LSU]), .lsu_uop(lsu_in), .lsu_ready(ready[FU_LSU]),
        .lsu_issue_valid(issue_valid[FU_LSU]), .lsu_issue_uop(lsu_out),
        .lsu_fu_ready(fu_ready[FU_LSU]), .lsu_executing(executing[FU_LSU]),
        .lsu_executing_tag(exec_tag[FU_LSU]),
        .bru_valid(valid[FU_BRU]), .bru_uop(exec_in[FU_BRU]), .bru_ready(ready[FU_BRU]),
        .bru_issue_valid(issue_valid[FU_BRU]), .bru_issue_uop(exec_out[FU_BRU]),
        .bru_fu_ready(fu_ready[FU_BRU]), .bru_executing(executing[FU_BRU]),
        .bru_executing_tag(exec_tag[FU_BRU]),
        .alu_valid(valid[FU_ALU]), .alu_uop(exec_in[FU_ALU]), .alu_ready(ready[FU_ALU]),
        .alu_issue_valid(issue_valid[FU_ALU]), .alu_issue_uop(exec_out[FU_ALU]),
        .alu_fu_ready(fu_ready[FU_ALU]), .alu_executing(executing[FU_ALU]),
        .alu_executing_tag(exec_tag[FU_ALU]),
        .fpu_valid(valid[FU_FPU]), .fpu_uop(exec_in[FU_FPU]), .fpu_ready(ready[FU_FPU]),
        .fpu_issue_valid(issue_valid[FU_FPU]), .fpu_issue_uop(exec_out[FU_FPU]),
        .fpu_fu_ready(fu_ready[FU_FPU]), .fpu_executing(executing[FU_FPU]),
        .fpu_executing_tag(exec_tag[FU_FPU])
    );

    initial begin
        forever #2 clk_in = ~clk_in;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ready rule: below threshold, below depth, and not in the first cycle out of reset
    function automatic logic expected_ready(input int occ, input logic [OCC_W-1:0] thr,
                                            input logic active);
        return active && (occ < int'(thr)) && (occ < IQ_DEPTH);
    endfunction

    function automatic logic addr_mapped(input logic [7:0] addr);
        return addr inside {REG_CTRL, REG_THRESH, REG_STATUS, REG_CNT0, REG_CNT1,
                            REG_CNT2, REG_CNT3};
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [7:0] addr);
        logic [31:0] d;
        d = '0;
        case (addr)
            REG_CTRL: d[NUM_FU-1:0] = m_en;
            REG_THRESH: begin
                for (int i = 0; i < NUM_FU; i++) begin
                    d[i*OCC_W +: OCC_W] = m_thr[i];
                end
            end
            REG_STATUS: begin
                for (int i = 0; i < NUM_FU; i++) begin
                    d[i*OCC_W +: OCC_W] = OCC_W'(wr_ptr[i] - rd_ptr[i]);
                end
            end
            REG_CNT0: d[CNT_W-1:0] = m_cnt[0];
            REG_CNT1: d[CNT_W-1:0] = m_cnt[1];
            REG_CNT2: d[CNT_W-1:0] = m_cnt[2];
            REG_CNT3: d[CNT_W-1:0] = m_cnt[3];
            default: d = '0;
        endcase
        return d;
    endfunction

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int u = 0; u < NUM_FU; u++) begin
            if (wr_ptr[u] != rd_ptr[u]) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    function automatic int unsigned assertion_failures();
        return dut0.u_lsu_iq.chk0.fail_count + dut0.u_bru_iq.chk0.fail_count
             + dut0.u_alu_iq.chk0.fail_count + dut0.u_fpu_iq.chk0.fail_count;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_exec_uop(input string name, input exec_uop_t got,
                                  input exec_uop_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_mem_uop(input string name, input mem_uop_t got, input mem_uop_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            REG_CTRL: m_en = data[NUM_FU-1:0];
            REG_THRESH: begin
                for (int i = 0; i < NUM_FU; i++) begin
                    m_thr[i] = data[i*OCC_W +: OCC_W];
                end
            end
            REG_CNT0: m_cnt[0] = '0;
            REG_CNT1: m_cnt[1] = '0;
            REG_CNT2: m_cnt[2] = '0;
            REG_CNT3: m_cnt[3] = '0;
            default: ;
        endcase
    endtask

    // reference side, all model updates happen here on the rising edge
    always @(posedge clk_in) begin : monitor
        int occ;
        logic exp_iv;
        logic exp_rdy;
        logic access;
        logic [ENTRY_W-1:0] head;
        mem_uop_t exp_mem;
        exec_uop_t exp_exec;
        access = apb_req.psel && apb_req.penable;
        if (!arst_n) begin
            for (int u = 0; u < NUM_FU; u++) begin
                check_bit($sformatf("%s_ready", names[u]), ready[u], 1'b0);
                check_bit($sformatf("%s_issue_valid", names[u]), issue_valid[u], 1'b0);
                check_bit($sformatf("%s_executing", names[u]), executing[u], 1'b0);
            end
            check_bit("pslverr", apb_rsp.pslverr, 1'b0);
        end else begin
            if (assertion_failures() != 0) begin
                stop_on_error("a bound assertion on an issue queue failed");
            end
            // register reads see the model before this edge
            check_bit("pslverr", apb_rsp.pslverr, access && (!addr_mapped(apb_req.paddr)
                      || (apb_req.pwrite && apb_req.paddr == REG_STATUS)));
            if (access && !apb_req.pwrite && addr_mapped(apb_req.paddr)) begin
                check_word("prdata", apb_rsp.prdata, expected_rdata(apb_req.paddr));
            end
            for (int u = 0; u < NUM_FU; u++) begin
                occ = wr_ptr[u] - rd_ptr[u];
                exp_iv = m_en[u] && (occ != 0);
                exp_rdy = expected_ready(occ, m_thr[u], m_active);
                check_bit($sformatf("%s_ready", names[u]), ready[u], exp_rdy);
                check_bit($sformatf("%s_issue_valid", names[u]), issue_valid[u], exp_iv);
                check_bit($sformatf("%s_executing", names[u]), executing[u], exec_pend[u]);
                if (exec_pend[u]) begin
                    check_tag($sformatf("%s_executing_tag", names[u]), exec_tag[u], pend_tag[u]);
                end
                exec_pend[u] = 1'b0;
                accepted[u] = 1'b0;
                if (flush_in) begin
                    rd_ptr[u] = wr_ptr[u];
                end else begin
                    if (exp_iv && fu_ready[u]) begin
                        head = model_mem[u][rd_ptr[u] % MODEL_SIZE];
                        if (u == FU_LSU) begin
                            exp_mem = mem_uop_t'(head[$bits(mem_uop_t)-1:0]);
                            check_mem_uop("lsu_issue_uop", lsu_out, exp_mem);
                            pend_tag[u] = exp_mem.tag;
                        end else begin
                            exp_exec = exec_uop_t'(head);
                            check_exec_uop($sformatf("%s_issue_uop", names[u]), exec_out[u],
                                           exp_exec);
                            pend_tag[u] = exp_exec.tag;
                        end
                        exec_pend[u] = 1'b1;
                        rd_ptr[u] = rd_ptr[u] + 1;
                        if (m_cnt[u] != '1) begin
                            m_cnt[u] = m_cnt[u] + 1'b1;
                        end
                    end
                    if (valid[u] && exp_rdy) begin
                        if (u == FU_LSU) begin
                            model_mem[u][wr_ptr[u] % MODEL_SIZE] = ENTRY_W'(lsu_in);
                        end else begin
                            model_mem[u][wr_ptr[u] % MODEL_SIZE] = exec_in[u];
                        end
                        wr_ptr[u] = wr_ptr[u] + 1;
                        accepted[u] = 1'b1;
                    end
                end
            end
            // a write lands after the counters so that clearing wins
            if (access && apb_req.pwrite && addr_mapped(apb_req.paddr)) begin
                apply_write(apb_req.paddr, apb_req.pwdata);
            end
            m_active = 1'b1;
        end
    end

    task automatic load_uop(input int u);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        if (u == FU_LSU) begin
            lsu_in = '{tag: next_tag[u], opcode: r0[5:0], base: r1, offset: r2[11:0],
                       is_store: r2[12]};
        end else begin
            exec_in[u] = '{tag: next_tag[u], opcode: r0[5:0], src_a: r1, src_b: r2};
        end
        next_tag[u] = next_tag[u] + 1'b1;
    endtask

    // one cycle of traffic; fu mode 0 holds fu_ready low, 1 is random, 2 is always high
    task automatic step(input logic [NUM_FU-1:0] send_mask, input int fu_mode);
        logic [31:0] r;
        @(negedge clk_in);
        for (int u = 0; u < NUM_FU; u++) begin
            r = next_rand();
            if (!valid[u] || accepted[u]) begin
                valid[u] = send_mask[u] && r[0];
                if (valid[u]) begin
                    load_uop(u);
                end
            end
            case (fu_mode)
                0: fu_ready[u] = 1'b0;
                1: fu_ready[u] = r[1];
                default: fu_ready[u] = 1'b1;
            endcase
        end
    endtask

    task automatic drain_queues();
        int n;
        n = 0;
        do begin
            step('0, 2);
            n++;
        end while ((valid != '0 || !model_empty()) && n < 200);
        if (valid != '0 || !model_empty()) begin
            stop_on_error("the issue queues did not drain before the timeout");
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data);
        @(negedge clk_in);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(negedge clk_in);
        apb_req.penable = 1'b1;
        @(negedge clk_in);
        apb_req = '0;
    endtask

    task automatic read_all_regs();
        apb_access(1'b0, REG_CTRL, '0);
        apb_access(1'b0, REG_THRESH, '0);
        apb_access(1'b0, REG_STATUS, '0);
        apb_access(1'b0, REG_CNT0, '0);
        apb_access(1'b0, REG_CNT1, '0);
        apb_access(1'b0, REG_CNT2, '0);
        apb_access(1'b0, REG_CNT3, '0);
    endtask

    initial begin
        arst_n = 1'b0;
        flush_in = 1'b0;
        apb_req = '0;
        valid = '0;
        fu_ready = '0;
        lsu_in = '0;
        exec_in = '0;
        rng_state = 32'd52675;
        m_en = CTRL_RESET;
        m_active = 1'b0;
        exec_pend = '0;
        accepted = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            wr_ptr[u] = 0;
            rd_ptr[u] = 0;
            m_thr[u] = THRESH_RESET;
            m_cnt[u] = '0;
            next_tag[u] = '0;
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        read_all_regs();

        // in order issue under random back-pressure
        repeat (300) step('1, 1);
        drain_queues();
        read_all_regs();
        apb_access(1'b1, REG_CNT1, 32'h0000_1234);
        apb_access(1'b0, REG_CNT1, '0);

        // ready falls at a threshold of three and rises after one issue
        apb_access(1'b1, REG_THRESH, 32'h0000_3333);
        cyc = 0;
        while (ready != '0 && cyc < 60) begin
            step('1, 0);
            cyc++;
        end
        if (ready != '0) begin
            stop_on_error("ready did not fall at the programmed threshold");
        end
        @(negedge clk_in);
        valid = '0;
        apb_access(1'b0, REG_STATUS, '0);
        step('0, 2);
        step('0, 0);
        if (ready != '1) begin
            stop_on_error("ready did not rise again after an issue");
        end
        drain_queues();
        apb_access(1'b1, REG_THRESH, 32'h0000_8888);

        // alu disabled while the other units keep issuing
        apb_access(1'b1, REG_CTRL, 32'h0000_000B);
        bru_before = m_cnt[FU_BRU];
        repeat (60) step('1, 1);
        if (m_cnt[FU_BRU] == bru_before) begin
            stop_on_error("the branch unit did not issue while the alu was disabled");
        end
        apb_access(1'b0, REG_STATUS, '0);
        apb_access(1'b1, REG_CTRL, 32'h0000_000F);
        drain_queues();

        // flush with valid held, the flush cycle enqueue is dropped
        repeat (20) step('1, 0);
        @(negedge clk_in);
        flush_in = 1'b1;
        fu_ready = '0;
        @(negedge clk_in);
        flush_in = 1'b0;
        apb_access(1'b0, REG_STATUS, '0);
        repeat (100) step('1, 1);
        drain_queues();

        // unmapped accesses and a status write are errors and change nothing
        apb_access(1'b1, 8'h1C, 32'hFFFF_FFFF);
        apb_access(1'b1, REG_STATUS, 32'hFFFF_FFFF);
        apb_access(1'b0, 8'h40, '0);
        apb_access(1'b1, 8'h03, 32'h0000_0000);
        read_all_regs();

        repeat (4) @(negedge clk_in);
        if (assertion_failures() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_error("a bound assertion on an issue queue failed");
        end
    end

endmodule

`default_nettype wire
